//--- Bender.yml
package:
  name: taint_tracker

export_include_dirs:
  - common

sources:
  - common/taint_pkg.sv
  - common/taint_op_if.sv
  - common/taint_wr_if.sv
  - logic/taint_issue.sv
  - taint_alu/taint_alu.sv
  - taint_store/taint_store.sv
  - logic/taint_tracker_top.sv
  - target: test
    files:
      - testbench/taint_ref_check.sv
      - testbench/taint_tracker_tb.sv

//--- common/taint_op_if.sv
interface taint_op_if;

    logic              valid;
    taint_pkg::op_e    opcode;
    taint_pkg::data_t  a;
    taint_pkg::data_t  b;
    taint_pkg::data_t  a_taint;
    taint_pkg::data_t  b_taint;
    logic              sel;
    logic              sel_taint;
    taint_pkg::addr_t  dst;
    logic              dst_taint;

    modport issue (
        output valid, opcode, a, b, a_taint, b_taint,
        output sel, sel_taint, dst, dst_taint
    );

    modport alu (
        input valid, opcode, a, b, a_taint, b_taint,
        input sel, sel_taint, dst, dst_taint
    );

endinterface

//--- common/taint_params.svh
`ifndef TAINT_PARAMS_SVH
`define TAINT_PARAMS_SVH

// operand values and taint masks share one width
`define TAINT_DATA_W 16

// taint store geometry
`define TAINT_ADDR_W 4
`define TAINT_DEPTH  16

// trace hash of tainted/untainted transitions
`define TAINT_HASH_W 16

`endif

//--- common/taint_pkg.sv
`include "taint_params.svh"

package taint_pkg;

    // operations the unit propagates taint through
    typedef enum logic [3:0] {
        OP_AND = 4'd0,
        OP_OR  = 4'd1,
        OP_XOR = 4'd2,
        OP_ADD = 4'd3,
        OP_SUB = 4'd4,
        OP_SHL = 4'd5,
        OP_SHR = 4'd6,
        OP_EQ  = 4'd7,
        OP_MUX = 4'd8
    } op_e;

    typedef logic [`TAINT_DATA_W-1:0] data_t;
    typedef logic [`TAINT_ADDR_W-1:0] addr_t;

    // one extra bit so a fully tainted store can be counted
    typedef logic [`TAINT_ADDR_W:0] count_t;

    typedef logic [`TAINT_HASH_W-1:0] hash_t;

endpackage

//--- common/taint_wr_if.sv
interface taint_wr_if;

    logic              valid;
    taint_pkg::addr_t  dst;
    logic              dst_taint;
    taint_pkg::data_t  taint;

    modport alu (
        output valid, dst, dst_taint, taint
    );

    modport store (
        input valid, dst, dst_taint, taint
    );

endinterface

//--- compile.f
+incdir+common
common/taint_pkg.sv
common/taint_op_if.sv
common/taint_wr_if.sv
logic/taint_issue.sv
taint_alu/taint_alu.sv
taint_store/taint_store.sv
logic/taint_tracker_top.sv
testbench/taint_ref_check.sv
testbench/taint_tracker_tb.sv

//--- logic/taint_issue.sv
module taint_issue (
    input  logic              pos_clk,
    input  logic              pos_arst,
    input  logic              op_valid,
    input  taint_pkg::op_e    op_code,
    input  taint_pkg::data_t  op_a,
    input  taint_pkg::data_t  op_b,
    input  taint_pkg::data_t  op_a_taint,
    input  taint_pkg::data_t  op_b_taint,
    input  logic              op_sel,
    input  logic              op_sel_taint,
    input  taint_pkg::addr_t  op_dst,
    input  logic              op_dst_taint,
    taint_op_if.issue         op
);

    // strobe is registered every cycle so a single-cycle valid stays single-cycle
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= op_valid;
        end
    end

    // operation fields only move when a new operation arrives
    always_ff @(posedge pos_clk) begin
        if (op_valid) begin
            op.opcode    <= op_code;
            op.a         <= op_a;
            op.b         <= op_b;
            op.a_taint   <= op_a_taint;
            op.b_taint   <= op_b_taint;
            op.sel       <= op_sel;
            op.sel_taint <= op_sel_taint;
            op.dst       <= op_dst;
            op.dst_taint <= op_dst_taint;
        end
    end

endmodule

//--- logic/taint_tracker_top.sv
module taint_tracker_top (
    input  logic              pos_clk,
    input  logic              pos_arst,
    input  logic              op_valid,
    input  taint_pkg::op_e    op_code,
    input  taint_pkg::data_t  op_a,
    input  taint_pkg::data_t  op_b,
    input  taint_pkg::data_t  op_a_taint,
    input  taint_pkg::data_t  op_b_taint,
    input  logic              op_sel,
    input  logic              op_sel_taint,
    input  taint_pkg::addr_t  op_dst,
    input  logic              op_dst_taint,
    output logic              result_valid,
    output taint_pkg::data_t  result_taint,
    input  logic              rd_en,
    input  taint_pkg::addr_t  rd_addr,
    output logic              rd_valid,
    output taint_pkg::data_t  rd_taint,
    output taint_pkg::count_t taint_sum,
    output taint_pkg::hash_t  trace_hash
);

    taint_op_if op_if ();
    taint_wr_if wr_if ();

    taint_issue i_issue (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .op_valid     (op_valid),
        .op_code      (op_code),
        .op_a         (op_a),
        .op_b         (op_b),
        .op_a_taint   (op_a_taint),
        .op_b_taint   (op_b_taint),
        .op_sel       (op_sel),
        .op_sel_taint (op_sel_taint),
        .op_dst       (op_dst),
        .op_dst_taint (op_dst_taint),
        .op           (op_if.issue)
    );

    taint_alu i_alu (
        .pos_clk  (pos_clk),
        .pos_arst (pos_arst),
        .op       (op_if.alu),
        .wr       (wr_if.alu)
    );

    taint_store i_store (
        .pos_clk    (pos_clk),
        .pos_arst   (pos_arst),
        .wr         (wr_if.store),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_taint   (rd_taint),
        .taint_sum  (taint_sum),
        .trace_hash (trace_hash)
    );

    // result is visible at the same edge it is written into the store
    assign result_valid = wr_if.valid;
    assign result_taint = wr_if.taint;

endmodule

//--- taint_alu/taint_alu.sv
`include "taint_params.svh"

module taint_alu (
    input  logic    pos_clk,
    input  logic    pos_arst,
    taint_op_if.alu op,
    taint_wr_if.alu wr
);

    localparam int SHAMT_W = $clog2(`TAINT_DATA_W);

    taint_pkg::data_t any_taint;
    taint_pkg::data_t a_lo;
    taint_pkg::data_t a_hi;
    taint_pkg::data_t b_lo;
    taint_pkg::data_t b_hi;
    taint_pkg::data_t and_t;
    taint_pkg::data_t or_t;
    taint_pkg::data_t xor_t;
    taint_pkg::data_t add_t;
    taint_pkg::data_t sub_t;
    taint_pkg::data_t shl_t;
    taint_pkg::data_t shr_t;
    taint_pkg::data_t eq_t;
    taint_pkg::data_t mux_t;
    taint_pkg::data_t result;
    logic             amt_tainted;
    logic             amt_overflow;

    assign any_taint = op.a_taint | op.b_taint;

    // bounds of each operand with the tainted bits forced low or high
    assign a_lo = op.a & ~op.a_taint;
    assign a_hi = op.a | op.a_taint;
    assign b_lo = op.b & ~op.b_taint;
    assign b_hi = op.b | op.b_taint;

    // a tainted bit matters unless the other side's clean bit already decides it
    assign and_t = (op.a_taint & op.b) | (op.b_taint & op.a) | (op.a_taint & op.b_taint);
    assign or_t  = (op.a_taint & ~op.b) | (op.b_taint & ~op.a) | (op.a_taint & op.b_taint);

    assign xor_t = {`TAINT_DATA_W{|any_taint}};

    // bits where the extreme sums disagree can be reached by a carry from taint
    assign add_t = ((a_lo + b_lo) ^ (a_hi + b_hi)) | any_taint;
    assign sub_t = ((a_lo - b_lo) ^ (a_hi - b_hi)) | any_taint;

    assign amt_tainted  = |op.b_taint;
    assign amt_overflow = op.b >= `TAINT_DATA_W;

    always_comb begin
        if (amt_tainted) begin
            shl_t = '1;
            shr_t = '1;
        end else if (amt_overflow) begin
            shl_t = '0;
            shr_t = '0;
        end else begin
            shl_t = op.a_taint << op.b[SHAMT_W-1:0];
            shr_t = op.a_taint >> op.b[SHAMT_W-1:0];
        end
    end

    // only the clean bits are compared and the result lives in bit 0
    always_comb begin
        eq_t    = '0;
        eq_t[0] = (|any_taint) && ((op.a & ~any_taint) == (op.b & ~any_taint));
    end

    always_comb begin
        mux_t = op.sel ? op.b_taint : op.a_taint;
        if (op.sel_taint) begin
            mux_t = mux_t | (op.a ^ op.b);
        end
    end

    always_comb begin
        case (op.opcode)
            taint_pkg::OP_AND: result = and_t;
            taint_pkg::OP_OR:  result = or_t;
            taint_pkg::OP_XOR: result = xor_t;
            taint_pkg::OP_ADD: result = add_t;
            taint_pkg::OP_SUB: result = sub_t;
            taint_pkg::OP_SHL: result = shl_t;
            taint_pkg::OP_SHR: result = shr_t;
            taint_pkg::OP_EQ:  result = eq_t;
            taint_pkg::OP_MUX: result = mux_t;
            // an unknown opcode taints everything when any input is tainted
            default:           result = xor_t;
        endcase
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= op.valid;
        end
    end

    always_ff @(posedge pos_clk) begin
        if (op.valid) begin
            wr.taint     <= result;
            wr.dst       <= op.dst;
            wr.dst_taint <= op.dst_taint;
        end
    end

endmodule

//--- taint_store/taint_store.sv
`include "taint_params.svh"

module taint_store (
    input  logic              pos_clk,
    input  logic              pos_arst,
    taint_wr_if.store         wr,
    input  logic              rd_en,
    input  taint_pkg::addr_t  rd_addr,
    output logic              rd_valid,
    output taint_pkg::data_t  rd_taint,
    output taint_pkg::count_t taint_sum,
    output taint_pkg::hash_t  trace_hash
);

    taint_pkg::data_t mem [`TAINT_DEPTH];
    taint_pkg::data_t wr_word;
    logic             was_tainted;
    logic             now_tainted;
    logic             status_flip;

    // a tainted address may have landed anywhere, so the whole entry is suspect
    assign wr_word     = wr.dst_taint ? '1 : wr.taint;
    assign was_tainted = |mem[wr.dst];
    assign now_tainted = |wr_word;
    assign status_flip = wr.valid && (was_tainted != now_tainted);

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < `TAINT_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.dst] <= wr_word;
        end
    end

    // count and hash only move when an entry changes between clean and tainted
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            taint_sum  <= '0;
            trace_hash <= '0;
        end else if (status_flip) begin
            if (now_tainted) begin
                taint_sum <= taint_sum + 1'b1;
            end else begin
                taint_sum <= taint_sum - 1'b1;
            end
            trace_hash <= (trace_hash << `TAINT_ADDR_W) ^ taint_pkg::hash_t'(wr.dst);
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // read sees the entry before a write at the same edge
    always_ff @(posedge pos_clk) begin
        if (rd_en) begin
            rd_taint <= mem[rd_addr];
        end
    end

endmodule

//--- testbench/taint_ref_check.sv
`include "taint_params.svh"

module taint_ref_check (
    input  logic              pos_clk,
    input  logic              pos_arst,
    input  logic              op_valid,
    input  taint_pkg::op_e    op_code,
    input  taint_pkg::data_t  op_a,
    input  taint_pkg::data_t  op_b,
    input  taint_pkg::data_t  op_a_taint,
    input  taint_pkg::data_t  op_b_taint,
    input  logic              op_sel,
    input  logic              op_sel_taint,
    input  taint_pkg::addr_t  op_dst,
    input  logic              op_dst_taint,
    input  logic              result_valid,
    input  taint_pkg::data_t  result_taint,
    input  logic              rd_en,
    input  taint_pkg::addr_t  rd_addr,
    input  logic              rd_valid,
    input  taint_pkg::data_t  rd_taint,
    input  taint_pkg::count_t taint_sum,
    input  taint_pkg::hash_t  trace_hash,
    output logic              failed,
    output logic              drained
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]      due;
        taint_pkg::data_t taint;
        taint_pkg::addr_t dst;
        logic             dst_taint;
    } result_exp_t;

    typedef struct packed {
        logic [31:0]      due;
        taint_pkg::data_t value;
    } read_exp_t;

    result_exp_t      res_q [$];
    read_exp_t        rd_q [$];
    result_exp_t      res_head;
    result_exp_t      res_new;
    read_exp_t        rd_head;
    read_exp_t        rd_new;
    taint_pkg::data_t model_mem [`TAINT_DEPTH];
    taint_pkg::hash_t model_hash;
    logic [31:0]      cycle;
    logic             wr_pending;
    taint_pkg::addr_t wr_addr;
    taint_pkg::data_t wr_word;

    initial failed = 1'b0;

    function automatic taint_pkg::data_t expected_taint(input taint_pkg::op_e code,
            input taint_pkg::data_t a, b, at, bt, input logic sel, sel_t);
        taint_pkg::data_t any_t;
        taint_pkg::data_t res;
        any_t = at | bt;
        res   = '0;
        case (code)
            taint_pkg::OP_AND: res = (at & bt) | (at & b) | (bt & a);
            taint_pkg::OP_OR:  res = (at & bt) | (at & ~b) | (bt & ~a);
            taint_pkg::OP_XOR: res = (any_t != '0) ? '1 : '0;
            taint_pkg::OP_ADD: res = (((a & ~at) + (b & ~bt)) ^ ((a | at) + (b | bt))) | any_t;
            taint_pkg::OP_SUB: res = (((a & ~at) - (b & ~bt)) ^ ((a | at) - (b | bt))) | any_t;
            taint_pkg::OP_SHL: res = (bt != '0) ? '1 : ((b < `TAINT_DATA_W) ? at << b : '0);
            taint_pkg::OP_SHR: res = (bt != '0) ? '1 : ((b < `TAINT_DATA_W) ? at >> b : '0);
            taint_pkg::OP_EQ:  res[0] = (any_t != '0) && (((a ^ b) & ~any_t) == '0);
            taint_pkg::OP_MUX: res = (sel ? bt : at) | (sel_t ? (a ^ b) : '0);
            default:           res = '0;
        endcase
        return res;
    endfunction

    function automatic taint_pkg::count_t count_tainted();
        taint_pkg::count_t n;
        n = '0;
        for (int i = 0; i < `TAINT_DEPTH; i++) begin
            if (model_mem[i] != '0) n = n + 1'b1;
        end
        return n;
    endfunction

    task automatic report_problem(input string what);
        if (!failed) $display("ERROR at %0d ns: %s", $time, what);
        failed = 1'b1;
    endtask

    task automatic check_data(input string name, input taint_pkg::data_t exp,
            input taint_pkg::data_t act);
        if (act !== exp) begin
            if (!failed) $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
            failed = 1'b1;
        end
    endtask

    task automatic check_count(input string name, input taint_pkg::count_t exp,
            input taint_pkg::count_t act);
        if (act !== exp) begin
            if (!failed) begin
                $display("[FAIL] %0d ns %s expected %0d actual %0d", $time, name, exp, act);
            end
            failed = 1'b1;
        end
    endtask

    task automatic check_hash(input string name, input taint_pkg::hash_t exp,
            input taint_pkg::hash_t act);
        if (act !== exp) begin
            if (!failed) $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
            failed = 1'b1;
        end
    endtask

    always @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_q.delete();
            rd_q.delete();
            for (int i = 0; i < `TAINT_DEPTH; i++) model_mem[i] = '0;
            model_hash = '0;
            cycle      = '0;
            drained    = 1'b1;
        end else begin
            cycle      = cycle + 1;
            wr_pending = 1'b0;
            // sampled values reflect writes from earlier edges only
            check_count("taint_sum", count_tainted(), taint_sum);
            check_hash("trace_hash", model_hash, trace_hash);

            if (res_q.size() > 0 && res_q[0].due == cycle) begin
                res_head = res_q.pop_front();
                if (result_valid !== 1'b1) begin
                    report_problem("result_valid did not rise two cycles after op_valid");
                end else begin
                    check_data("result_taint", res_head.taint, result_taint);
                end
                wr_pending = 1'b1;
                wr_addr    = res_head.dst;
                wr_word    = res_head.dst_taint ? '1 : res_head.taint;
            end else if (result_valid !== 1'b0) begin
                report_problem("result_valid was high with no operation due");
            end

            if (rd_q.size() > 0 && rd_q[0].due == cycle) begin
                rd_head = rd_q.pop_front();
                if (rd_valid !== 1'b1) begin
                    report_problem("rd_valid did not rise one cycle after rd_en");
                end else begin
                    check_data("rd_taint", rd_head.value, rd_taint);
                end
            end else if (rd_valid !== 1'b0) begin
                report_problem("rd_valid was high with no read due");
            end

            // a read at this edge sees the entry before this edge's write
            if (rd_en) begin
                rd_new.due   = cycle + 1;
                rd_new.value = model_mem[rd_addr];
                rd_q.push_back(rd_new);
            end

            if (wr_pending) begin
                if ((model_mem[wr_addr] != '0) != (wr_word != '0)) begin
                    model_hash = (model_hash << `TAINT_ADDR_W) ^ taint_pkg::hash_t'(wr_addr);
                end
                model_mem[wr_addr] = wr_word;
            end

            if (op_valid) begin
                res_new.due       = cycle + 2;
                res_new.taint     = expected_taint(op_code, op_a, op_b, op_a_taint, op_b_taint,
                                                   op_sel, op_sel_taint);
                res_new.dst       = op_dst;
                res_new.dst_taint = op_dst_taint;
                res_q.push_back(res_new);
            end
            drained = (res_q.size() == 0) && (rd_q.size() == 0);
        end
    end

endmodule

//--- testbench/taint_tracker_tb.sv
`include "taint_params.svh"

module taint_tracker_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int N_RAND         = 120;
    localparam int N_OPS          = N_RAND + 11;
    localparam int N_READS        = `TAINT_DEPTH + 3;
    localparam int TIMEOUT_CYCLES = N_OPS + N_READS + 40;

    logic              pos_clk;
    logic              pos_arst;
    logic              op_valid;
    taint_pkg::op_e    op_code;
    taint_pkg::data_t  op_a;
    taint_pkg::data_t  op_b;
    taint_pkg::data_t  op_a_taint;
    taint_pkg::data_t  op_b_taint;
    logic              op_sel;
    logic              op_sel_taint;
    taint_pkg::addr_t  op_dst;
    logic              op_dst_taint;
    logic              result_valid;
    taint_pkg::data_t  result_taint;
    logic              rd_en;
    taint_pkg::addr_t  rd_addr;
    logic              rd_valid;
    taint_pkg::data_t  rd_taint;
    taint_pkg::count_t taint_sum;
    taint_pkg::hash_t  trace_hash;
    logic              check_failed;
    logic              check_drained;
    int unsigned       rng_seed = 32'h1783_3e40;

    taint_tracker_top i_dut (.*);

    taint_ref_check i_check (.*, .failed(check_failed), .drained(check_drained));

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic drive_op(input taint_pkg::op_e code, input taint_pkg::data_t a, b, at, bt,
            input logic sel, sel_t, input taint_pkg::addr_t dst, input logic dst_t);
        @(posedge pos_clk);
        op_valid     <= 1'b1;
        op_code      <= code;
        op_a         <= a;
        op_b         <= b;
        op_a_taint   <= at;
        op_b_taint   <= bt;
        op_sel       <= sel;
        op_sel_taint <= sel_t;
        op_dst       <= dst;
        op_dst_taint <= dst_t;
        rd_en        <= 1'b0;
    endtask

    task automatic read_entry(input taint_pkg::addr_t addr);
        @(posedge pos_clk);
        op_valid <= 1'b0;
        rd_en    <= 1'b1;
        rd_addr  <= addr;
    endtask

    task automatic idle_cycle();
        @(posedge pos_clk);
        op_valid <= 1'b0;
        rd_en    <= 1'b0;
    endtask

    // sparse taint and small shift amounts so every rule branch gets hit
    task automatic random_op();
        taint_pkg::data_t at;
        taint_pkg::data_t bt;
        taint_pkg::data_t b;
        at = ($urandom_range(0, 3) == 0) ? '0 : taint_pkg::data_t'($urandom);
        bt = ($urandom_range(0, 1) == 0) ? '0 : taint_pkg::data_t'($urandom);
        b  = ($urandom_range(0, 1) == 0) ? taint_pkg::data_t'($urandom_range(0, 19))
                                         : taint_pkg::data_t'($urandom);
        drive_op(taint_pkg::op_e'($urandom_range(0, 8)), taint_pkg::data_t'($urandom), b, at, bt,
                 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                 taint_pkg::addr_t'($urandom_range(0, 15)), $urandom_range(0, 7) == 0);
        rd_en   <= 1'($urandom_range(0, 1));
        rd_addr <= taint_pkg::addr_t'($urandom_range(0, 15));
    endtask

    initial begin
        pos_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run("timeout, the run did not finish within the expected number of cycles");
    end

    initial begin
        wait (check_failed === 1'b1);
        abort_run("the result checker found a mismatch");
    end

    initial begin
        void'($urandom(rng_seed));
        pos_arst     = 1'b1;
        op_valid     = 1'b0;
        op_code      = taint_pkg::OP_AND;
        op_a         = '0;
        op_b         = '0;
        op_a_taint   = '0;
        op_b_taint   = '0;
        op_sel       = 1'b0;
        op_sel_taint = 1'b0;
        op_dst       = '0;
        op_dst_taint = 1'b0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        repeat (16) @(posedge pos_clk);
        pos_arst <= 1'b0;

        for (int i = 0; i < `TAINT_DEPTH; i++) read_entry(taint_pkg::addr_t'(i));
        repeat (N_RAND) random_op();

        // tainted address first so its entry can be read back at the end of the group
        drive_op(taint_pkg::OP_AND, 16'h00f0, 16'h0ff0, '0, '0, 1'b0, 1'b0, 4'd5, 1'b1);
        drive_op(taint_pkg::OP_SHL, 16'h1234, 16'h0003, 16'h0001, 16'h0004, 1'b0, 1'b0, 4'd1, 1'b0);
        drive_op(taint_pkg::OP_SHR, 16'h8000, 16'h0002, 16'h0100, 16'h0001, 1'b0, 1'b0, 4'd2, 1'b0);
        drive_op(taint_pkg::OP_MUX, 16'haaaa, 16'h5a5a, 16'h0003, 16'h0300, 1'b1, 1'b1, 4'd3, 1'b0);
        drive_op(taint_pkg::OP_EQ, 16'h1234, 16'h1234, '0, '0, 1'b0, 1'b0, 4'd4, 1'b0);
        read_entry(4'd5);

        // taint, retaint, clear, clear again, then a folded address entry
        drive_op(taint_pkg::OP_OR, '0, '0, 16'h000f, '0, 1'b0, 1'b0, 4'd9, 1'b0);
        drive_op(taint_pkg::OP_ADD, 16'h0010, 16'h0001, 16'h0001, '0, 1'b0, 1'b0, 4'd9, 1'b0);
        drive_op(taint_pkg::OP_XOR, 16'h00ff, 16'h0f0f, '0, '0, 1'b0, 1'b0, 4'd9, 1'b0);
        drive_op(taint_pkg::OP_AND, 16'hffff, 16'h0001, '0, '0, 1'b0, 1'b0, 4'd9, 1'b0);
        drive_op(taint_pkg::OP_EQ, 16'h0001, 16'h0002, '0, '0, 1'b0, 1'b0, 4'd10, 1'b1);
        drive_op(taint_pkg::OP_SHR, 16'hf000, 16'h0004, '0, '0, 1'b0, 1'b0, 4'd10, 1'b0);
        read_entry(4'd9);
        read_entry(4'd10);
        idle_cycle();

        while (!check_drained) @(negedge pos_clk);
        repeat (2) @(posedge pos_clk);
        if (check_failed) begin
            abort_run("a check failed before the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
